// ==== filelist.f ====
+incdir+test
source/vending_pkg.sv
source/display_pkg.sv
source/button_conditioner.sv
source/vending_fsm.sv
source/balance_display.sv
source/vending_top.sv
test/vending_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it; pass needs the pass line in the output.
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -j 0 -f filelist.f \
    --top-module vending_tb -o vending_sim &&
./obj_dir/vending_sim | tee /dev/stderr | grep "TEST PASSED" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== test/vending_model.svh ====
`ifndef VENDING_MODEL_SVH
`define VENDING_MODEL_SVH

// button positions used by the stimulus.
localparam int BTN_COIN_SMALL  = 0;
localparam int BTN_COIN_MEDIUM = 1;
localparam int BTN_COIN_LARGE  = 2;
localparam int BTN_CANCEL      = 3;
localparam int BTN_SEL_COKE    = 4;
localparam int BTN_SEL_OOLONG  = 5;
localparam int BTN_SEL_WATER   = 6;
localparam int BTN_SEL_COFFEE  = 7;
localparam int BTN_COUNT       = 8;

vending_pkg::balance_t expected_balance;

function automatic vending_pkg::product_set_t lamps_for(input vending_pkg::balance_t credit);
    vending_pkg::product_set_t lit;
    lit.coke   = credit >= vending_pkg::PRICE_COKE;
    lit.oolong = credit >= vending_pkg::PRICE_OOLONG;
    lit.water  = credit >= vending_pkg::PRICE_WATER;
    lit.coffee = credit >= vending_pkg::PRICE_COFFEE;
    return lit;
endfunction

function automatic void clear_credit();
    expected_balance = '0;
endfunction

function automatic void add_coin(input vending_pkg::balance_t value);
    int sum;
    sum = int'(expected_balance) + int'(value);
    if (sum > int'(vending_pkg::BALANCE_MAX)) begin
        sum = int'(vending_pkg::BALANCE_MAX);  // capped credit.
    end
    expected_balance = vending_pkg::balance_t'(sum);
endfunction

function automatic logic buy_product(input vending_pkg::balance_t price);
    if (expected_balance < price) begin
        return 1'b0;
    end
    expected_balance = expected_balance - price;
    return 1'b1;
endfunction

// 1 when the press starts change return.
function automatic logic apply_press(input int which);
    logic returning;
    returning = 1'b0;
    case (which)
        BTN_COIN_SMALL:  add_coin(vending_pkg::COIN_SMALL);
        BTN_COIN_MEDIUM: add_coin(vending_pkg::COIN_MEDIUM);
        BTN_COIN_LARGE:  add_coin(vending_pkg::COIN_LARGE);
        BTN_CANCEL:      returning = 1'b1;
        BTN_SEL_COKE:    returning = buy_product(vending_pkg::PRICE_COKE);
        BTN_SEL_OOLONG:  returning = buy_product(vending_pkg::PRICE_OOLONG);
        BTN_SEL_WATER:   returning = buy_product(vending_pkg::PRICE_WATER);
        BTN_SEL_COFFEE:  returning = buy_product(vending_pkg::PRICE_COFFEE);
        default:         returning = 1'b0;
    endcase
    return returning;
endfunction

function automatic void return_step();
    if (expected_balance > vending_pkg::CHANGE_STEP) begin
        expected_balance = expected_balance - vending_pkg::CHANGE_STEP;
    end else begin
        expected_balance = '0;
    end
endfunction

function automatic display_pkg::segments_t pattern_for(input int digit);
    logic [6:0] lit;  // active high, a on bit 0.
    case (digit)
        0:       lit = 7'h3f;
        1:       lit = 7'h06;
        2:       lit = 7'h5b;
        3:       lit = 7'h4f;
        4:       lit = 7'h66;
        5:       lit = 7'h6d;
        6:       lit = 7'h7d;
        7:       lit = 7'h07;
        8:       lit = 7'h7f;
        9:       lit = 7'h6f;
        default: lit = 7'h00;
    endcase
    return ~lit;
endfunction

`endif

// ==== test/vending_tb.sv ====
module vending_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF_NS    = 10;
    localparam int CLK_PERIOD_NS  = 2 * CLK_HALF_NS;
    localparam int RESET_CYCLES   = 16;
    localparam int DRIVE_DELAY_NS = 2;
    localparam int HOLD_CYCLES    = 8;
    localparam int RANDOM_STEPS   = 60;
    localparam int DIRECTED_STEPS = 10;
    // press, release, a full 80 to 0 return and a scan check.
    localparam int STEP_CYCLES = 4 * HOLD_CYCLES + 16 * (vending_pkg::CHANGE_TICK_CYCLES + 2)
                                 + 2 * display_pkg::SCAN_CYCLES;
    localparam int WATCHDOG_NS = 2 * (RANDOM_STEPS + DIRECTED_STEPS) * STEP_CYCLES
                                 * CLK_PERIOD_NS;

    logic                      clk;
    logic                      rst;
    vending_pkg::button_set_t  buttons;
    vending_pkg::product_set_t lamps;
    display_pkg::segments_t    seg;
    display_pkg::anodes_t      an;
    integer                    seed;

    `include "vending_model.svh"

    vending_top vending_top_inst (
        .clk     (clk),
        .rst     (rst),
        .buttons (buttons),
        .lamps   (lamps),
        .seg     (seg),
        .an      (an)
    );

    always #CLK_HALF_NS clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h",
                                name, actual, expected));
        end
    endtask

    function automatic vending_pkg::button_set_t button_for(input int which);
        vending_pkg::button_set_t pressed;
        pressed = '0;
        case (which)
            BTN_COIN_SMALL:  pressed.coin_small  = 1'b1;
            BTN_COIN_MEDIUM: pressed.coin_medium = 1'b1;
            BTN_COIN_LARGE:  pressed.coin_large  = 1'b1;
            BTN_CANCEL:      pressed.cancel      = 1'b1;
            BTN_SEL_COKE:    pressed.sel_coke    = 1'b1;
            BTN_SEL_OOLONG:  pressed.sel_oolong  = 1'b1;
            BTN_SEL_WATER:   pressed.sel_water   = 1'b1;
            default:         pressed.sel_coffee  = 1'b1;
        endcase
        return pressed;
    endfunction

    task automatic press_button(input int which, input int hold);
        @(posedge clk);
        #DRIVE_DELAY_NS;
        buttons = button_for(which);
        repeat (hold) @(posedge clk);
        #DRIVE_DELAY_NS;
        buttons = '0;
        repeat (HOLD_CYCLES) @(posedge clk);  // release gap.
    endtask

    task automatic check_outputs();
        int tens;
        int ones;
        tens = int'(expected_balance) / 10;
        ones = int'(expected_balance) % 10;
        @(negedge clk);
        check_value("balance", 32'(vending_top_inst.balance), 32'(expected_balance));
        check_value("lamps", 32'(lamps), 32'(lamps_for(expected_balance)));
        repeat (2 * display_pkg::SCAN_CYCLES) begin
            @(negedge clk);
            if (an == display_pkg::ANODE_TENS) begin
                check_value("seg", 32'(seg), 32'(pattern_for(tens)));
            end else begin
                check_value("an", 32'(an), 32'(display_pkg::ANODE_ONES));
                check_value("seg", 32'(seg), 32'(pattern_for(ones)));
            end
        end
    endtask

    task automatic follow_return();
        int  waited;
        logic first;
        first = 1'b1;
        while (expected_balance != '0) begin
            waited = 0;
            while (vending_top_inst.balance == expected_balance
                   && waited < vending_pkg::CHANGE_TICK_CYCLES + HOLD_CYCLES) begin
                @(negedge clk);
                waited++;
            end
            return_step();
            check_value("balance", 32'(vending_top_inst.balance), 32'(expected_balance));
            check_value("lamps", 32'(lamps), 32'(lamps_for(expected_balance)));
            if (!first) begin
                check_value("change tick spacing", 32'(waited),
                            32'(vending_pkg::CHANGE_TICK_CYCLES));
            end
            first = 1'b0;
        end
        waited = 0;
        while (vending_top_inst.vending_fsm_inst.state != vending_pkg::TAKE_COINS
               && waited < HOLD_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        check_value("state", 32'(vending_top_inst.vending_fsm_inst.state),
                    32'(vending_pkg::TAKE_COINS));
    endtask

    // late_coin below 0 means no coin during the return.
    task automatic run_step(input int which, input int hold, input int late_coin);
        logic returning;
        press_button(which, hold);
        returning = apply_press(which);
        if (returning) begin
            if (late_coin >= 0 && expected_balance != '0) begin
                fork
                    press_button(late_coin, HOLD_CYCLES);
                    follow_return();
                join
            end else begin
                follow_return();
            end
        end
        check_outputs();
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before all steps finished");
    end

    initial begin
        int which;
        int late_coin;
        seed    = 14;
        clk     = 1'b0;
        rst     = 1'b1;
        buttons = '0;
        clear_credit();
        repeat (RESET_CYCLES) @(posedge clk);
        check_value("an", 32'(an), 32'(display_pkg::ANODE_ONES));
        check_value("lamps", 32'(lamps), 32'(lamps_for(expected_balance)));
        #DRIVE_DELAY_NS;
        rst = 1'b0;
        check_outputs();

        run_step(BTN_COIN_LARGE, HOLD_CYCLES, -1);
        press_button(BTN_COIN_MEDIUM, vending_pkg::DEBOUNCE_DEPTH - 1);  // too short.
        check_outputs();
        run_step(BTN_COIN_MEDIUM, 3 * HOLD_CYCLES, -1);  // long hold counts once.
        run_step(BTN_COIN_LARGE, HOLD_CYCLES, -1);  // second 50 saturates at 80.
        run_step(BTN_SEL_COFFEE, HOLD_CYCLES, BTN_COIN_MEDIUM);
        run_step(BTN_COIN_MEDIUM, HOLD_CYCLES, -1);
        run_step(BTN_SEL_COFFEE, HOLD_CYCLES, -1);  // not affordable.
        run_step(BTN_CANCEL, HOLD_CYCLES, BTN_COIN_LARGE);

        for (int step = 0; step < RANDOM_STEPS; step++) begin
            which     = $unsigned($random(seed)) % BTN_COUNT;
            late_coin = $unsigned($random(seed)) % 4;
            if (late_coin == 3) begin
                late_coin = -1;
            end
            run_step(which, HOLD_CYCLES, late_coin);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== source/vending_top.sv ====
module vending_top (
    input  logic                      clk,
    input  logic                      rst,
    input  vending_pkg::button_set_t  buttons,  // raw, unsynchronized.
    output vending_pkg::product_set_t lamps,
    output display_pkg::segments_t    seg,
    output display_pkg::anodes_t      an
);

    vending_pkg::button_set_t presses;
    vending_pkg::balance_t    balance;

    button_conditioner button_conditioner_inst (
        .clk     (clk),
        .rst     (rst),
        .buttons (buttons),
        .presses (presses)
    );

    vending_fsm vending_fsm_inst (
        .clk     (clk),
        .rst     (rst),
        .presses (presses),
        .balance (balance),
        .lamps   (lamps)
    );

    balance_display balance_display_inst (
        .clk     (clk),
        .rst     (rst),
        .balance (balance),
        .seg     (seg),
        .an      (an)
    );

endmodule

// ==== source/balance_display.sv ====
module balance_display (
    input  logic                   clk,
    input  logic                   rst,
    input  vending_pkg::balance_t  balance,
    output display_pkg::segments_t seg,
    output display_pkg::anodes_t   an
);

    display_pkg::digit_t      tens;
    display_pkg::digit_t      ones;
    display_pkg::digit_t      shown;
    display_pkg::scan_count_t scan_count;
    logic                     show_tens;
    logic                     scan_done;

    // balance never exceeds 80, so both fit one digit.
    assign tens = display_pkg::digit_t'(balance / 7'd10);
    assign ones = display_pkg::digit_t'(balance % 7'd10);

    assign scan_done = scan_count == display_pkg::scan_count_t'(display_pkg::SCAN_CYCLES - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_count <= '0;
            show_tens  <= 1'b0;
        end else if (scan_done) begin
            scan_count <= '0;
            show_tens  <= ~show_tens;  // swap digit.
        end else begin
            scan_count <= scan_count + 1'b1;
        end
    end

    always_comb begin
        if (show_tens) begin
            shown = tens;
            an    = display_pkg::ANODE_TENS;
        end else begin
            shown = ones;
            an    = display_pkg::ANODE_ONES;
        end
        seg = display_pkg::SEG_PATTERNS[shown];
    end

endmodule

// ==== source/vending_fsm.sv ====
module vending_fsm (
    input  logic                      clk,
    input  logic                      rst,
    input  vending_pkg::button_set_t  presses,
    output vending_pkg::balance_t     balance,
    output vending_pkg::product_set_t lamps
);

    vending_pkg::machine_state_t state;
    vending_pkg::machine_state_t state_next;
    vending_pkg::balance_t       balance_next;
    vending_pkg::tick_count_t    tick_count;
    vending_pkg::tick_count_t    tick_count_next;

    vending_pkg::product_set_t selects;
    vending_pkg::balance_t     coin_value;
    vending_pkg::balance_t     price;
    logic                      coin_seen;
    logic                      buy;
    logic                      tick_done;

    always_comb begin
        lamps.coke   = balance >= vending_pkg::PRICE_COKE;
        lamps.oolong = balance >= vending_pkg::PRICE_OOLONG;
        lamps.water  = balance >= vending_pkg::PRICE_WATER;
        lamps.coffee = balance >= vending_pkg::PRICE_COFFEE;
    end

    always_comb begin
        selects.coke   = presses.sel_coke;
        selects.oolong = presses.sel_oolong;
        selects.water  = presses.sel_water;
        selects.coffee = presses.sel_coffee;
    end

    always_comb begin
        coin_seen  = 1'b1;
        coin_value = '0;
        if (presses.coin_small) begin
            coin_value = vending_pkg::COIN_SMALL;
        end else if (presses.coin_medium) begin
            coin_value = vending_pkg::COIN_MEDIUM;
        end else if (presses.coin_large) begin
            coin_value = vending_pkg::COIN_LARGE;
        end else begin
            coin_seen = 1'b0;
        end
    end

    // dearest lit product wins.
    always_comb begin
        buy   = 1'b1;
        price = '0;
        if (selects.coffee && lamps.coffee) begin
            price = vending_pkg::PRICE_COFFEE;
        end else if (selects.water && lamps.water) begin
            price = vending_pkg::PRICE_WATER;
        end else if (selects.oolong && lamps.oolong) begin
            price = vending_pkg::PRICE_OOLONG;
        end else if (selects.coke && lamps.coke) begin
            price = vending_pkg::PRICE_COKE;
        end else begin
            buy = 1'b0;
        end
    end

    assign tick_done = tick_count == vending_pkg::tick_count_t'(vending_pkg::CHANGE_TICK_CYCLES - 1);

    always_comb begin
        state_next      = state;
        balance_next    = balance;
        tick_count_next = tick_count;
        case (state)
            vending_pkg::IDLE: begin
                state_next      = vending_pkg::TAKE_COINS;
                tick_count_next = '0;
            end
            vending_pkg::TAKE_COINS: begin
                tick_count_next = '0;
                if (presses.cancel) begin
                    state_next = vending_pkg::RETURN_CHANGE;
                end else if (coin_seen) begin
                    // compare before adding so the sum never wraps.
                    if (balance > vending_pkg::BALANCE_MAX - coin_value) begin
                        balance_next = vending_pkg::BALANCE_MAX;
                    end else begin
                        balance_next = balance + coin_value;
                    end
                end else if (buy) begin
                    balance_next = balance - price;
                    state_next   = vending_pkg::RETURN_CHANGE;
                end
            end
            vending_pkg::RETURN_CHANGE: begin
                if (balance == '0) begin
                    state_next      = vending_pkg::IDLE;
                    tick_count_next = '0;
                end else if (tick_done) begin
                    tick_count_next = '0;
                    if (balance > vending_pkg::CHANGE_STEP) begin
                        balance_next = balance - vending_pkg::CHANGE_STEP;
                    end else begin
                        balance_next = '0;
                    end
                end else begin
                    tick_count_next = tick_count + 1'b1;
                end
            end
            default: begin
                state_next = vending_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= vending_pkg::IDLE;
            balance    <= '0;
            tick_count <= '0;
        end else begin
            state      <= state_next;
            balance    <= balance_next;
            tick_count <= tick_count_next;
        end
    end

endmodule

// ==== source/button_conditioner.sv ====
module button_conditioner (
    input  logic                     clk,
    input  logic                     rst,
    input  vending_pkg::button_set_t buttons,
    output vending_pkg::button_set_t presses
);

    vending_pkg::sample_window_t samples [vending_pkg::BUTTON_COUNT];

    logic [vending_pkg::BUTTON_COUNT-1:0] raw;
    logic [vending_pkg::BUTTON_COUNT-1:0] level;
    logic [vending_pkg::BUTTON_COUNT-1:0] level_d;
    logic [vending_pkg::BUTTON_COUNT-1:0] pulse;

    assign raw = buttons;

    // stable only when every sample in the window is high.
    always_comb begin
        for (int i = 0; i < vending_pkg::BUTTON_COUNT; i++) begin
            level[i] = &samples[i];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < vending_pkg::BUTTON_COUNT; i++) begin
                samples[i] <= '0;
            end
            level_d <= '0;
            pulse   <= '0;
        end else begin
            for (int i = 0; i < vending_pkg::BUTTON_COUNT; i++) begin
                samples[i] <= {samples[i][vending_pkg::DEBOUNCE_DEPTH-2:0], raw[i]};
            end
            level_d <= level;
            pulse   <= level & ~level_d;  // rising edge only.
        end
    end

    assign presses = pulse;

endmodule

// ==== source/display_pkg.sv ====
package display_pkg;

    typedef logic [3:0] digit_t;

    // active low, segment a on bit 0.
    typedef logic [6:0] segments_t;

    // active low, digit 0 on bit 0.
    typedef logic [3:0] anodes_t;

    localparam segments_t SEG_PATTERNS [10] = '{
        7'b1000000,  // 0.
        7'b1111001,  // 1.
        7'b0100100,  // 2.
        7'b0110000,  // 3.
        7'b0011001,  // 4.
        7'b0010010,  // 5.
        7'b0000010,  // 6.
        7'b1111000,  // 7.
        7'b0000000,  // 8.
        7'b0010000   // 9.
    };

    localparam anodes_t ANODE_ONES = 4'b1110;
    localparam anodes_t ANODE_TENS = 4'b1101;

    localparam int SCAN_CYCLES = 8;
    typedef logic [$clog2(SCAN_CYCLES)-1:0] scan_count_t;

endpackage

// ==== source/vending_pkg.sv ====
package vending_pkg;

    localparam int BALANCE_WIDTH = 7;

    // credit held by the machine.
    typedef logic [BALANCE_WIDTH-1:0] balance_t;

    localparam balance_t BALANCE_MAX = 7'd80;

    localparam balance_t COIN_SMALL  = 7'd5;
    localparam balance_t COIN_MEDIUM = 7'd10;
    localparam balance_t COIN_LARGE  = 7'd50;

    localparam balance_t PRICE_COKE   = 7'd20;
    localparam balance_t PRICE_OOLONG = 7'd25;
    localparam balance_t PRICE_WATER  = 7'd30;
    localparam balance_t PRICE_COFFEE = 7'd55;

    localparam balance_t CHANGE_STEP = 7'd5;

    localparam int CHANGE_TICK_CYCLES = 16;
    typedef logic [$clog2(CHANGE_TICK_CYCLES)-1:0] tick_count_t;

    localparam int DEBOUNCE_DEPTH = 4;
    typedef logic [DEBOUNCE_DEPTH-1:0] sample_window_t;

    typedef struct packed {
        logic coin_small;
        logic coin_medium;
        logic coin_large;
        logic cancel;
        logic sel_coke;
        logic sel_oolong;
        logic sel_water;
        logic sel_coffee;
    } button_set_t;

    localparam int BUTTON_COUNT = $bits(button_set_t);

    // lamps and product selects share this layout.
    typedef struct packed {
        logic coke;
        logic oolong;
        logic water;
        logic coffee;
    } product_set_t;

    typedef enum logic [1:0] {IDLE, TAKE_COINS, RETURN_CHANGE} machine_state_t;

endpackage
